// ==== design/trap_pkg.sv ====
package trap_pkg;

    // trap kind seen by the controller
    typedef enum logic [2:0] {
        trap_none       = 3'd0,
        trap_fencei     = 3'd1,
        trap_mret       = 3'd2,
        trap_ecall      = 3'd3,
        trap_ebreak     = 3'd4,
        trap_misaligned = 3'd5
    } trap_status_e;

    // machine trap csr addresses
    localparam logic [11:0] csr_addr_mepc   = 12'h341;
    localparam logic [11:0] csr_addr_mcause = 12'h342;
    localparam logic [11:0] csr_addr_mtvec  = 12'h305;

    // mcause exception codes
    localparam logic [31:0] mcause_ecall      = 32'd11;  // ecall from m-mode
    localparam logic [31:0] mcause_ebreak     = 32'd3;   // breakpoint
    localparam logic [31:0] mcause_misaligned = 32'd0;   // instr addr misaligned

    // one csr write request
    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_access_t;

    // instruction fields the decoder looks at
    localparam logic [6:0]  opcode_system   = 7'b1110011;
    localparam logic [6:0]  opcode_misc_mem = 7'b0001111;
    localparam logic [11:0] funct12_ecall   = 12'h000;
    localparam logic [11:0] funct12_ebreak  = 12'h001;
    localparam logic [11:0] funct12_mret    = 12'h302;
    localparam logic [2:0]  funct3_fencei   = 3'b001;

endpackage

// ==== design/trap_decoder.sv ====
`timescale 1ns/100ps

module trap_decoder import trap_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic [31:0]  instr,
    input  logic         jump_valid,
    input  logic [31:0]  jump_target,
    input  logic         trap_done,
    input  logic         debug_mode,
    output trap_status_e status
);

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [11:0]  funct12;
    trap_status_e decoded;
    trap_status_e held;
    logic         held_valid;
    logic         multi_cycle;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct12 = instr[31:20];

    always_comb begin
        decoded = trap_none;
        if (jump_valid && jump_target[1:0] != 2'b00) begin
            decoded = trap_misaligned;  // bad jump beats the instruction itself
        end else if (opcode == opcode_system && funct3 == 3'b000) begin
            // privileged group, funct3 zero
            case (funct12)
                funct12_ecall:  decoded = trap_ecall;
                funct12_ebreak: decoded = trap_ebreak;
                funct12_mret:   decoded = trap_mret;
                default:        decoded = trap_none;
            endcase
        end else if (opcode == opcode_misc_mem && funct3 == funct3_fencei) begin
            decoded = trap_fencei;
        end
    end

    // kinds that run through the controller sequence
    assign multi_cycle = (decoded == trap_ecall) || (decoded == trap_ebreak) ||
                         (decoded == trap_misaligned);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (trap_done) begin
            held_valid <= 1'b0;  // sequence finished
        end else if (!held_valid && multi_cycle) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!trap_done && !held_valid && multi_cycle) begin
            held <= decoded;
        end
    end

    always_comb begin
        if (debug_mode) begin
            status = trap_none;  // core parked
        end else if (held_valid) begin
            status = held;
        end else begin
            status = decoded;
        end
    end

endmodule

// ==== design/trap_controller.sv ====
`timescale 1ns/100ps

module trap_controller import trap_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic [31:0]  pc,
    input  trap_status_e status,
    input  logic         debug_resume,
    input  logic [31:0]  trap_rd_data,
    output csr_access_t  csr_trap,
    output logic [11:0]  trap_rd_addr,
    output logic [31:0]  trap_target,
    output logic         redirect,
    output logic         ic_clean,
    output logic         debug_mode,
    output logic         trap_done
);

    typedef enum logic [1:0] {
        idle         = 2'b00,
        write_mepc   = 2'b01,
        write_mcause = 2'b10,
        read_mtvec   = 2'b11
    } state_e;

    state_e      state;
    state_e      next_state;
    logic        active;       // low until the first status is decoded
    logic [31:0] cause_code;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= idle;
            active <= 1'b0;
        end else begin
            state  <= next_state;
            active <= 1'b1;
        end
    end

    // debug mode flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            debug_mode <= 1'b0;
        end else if (state == write_mcause && status == trap_ebreak) begin
            debug_mode <= 1'b1;
        end else if (debug_resume) begin
            debug_mode <= 1'b0;
        end else if (active && state == idle && status == trap_mret) begin
            debug_mode <= 1'b0;
        end
    end

    always_comb begin
        case (status)
            trap_ecall:  cause_code = mcause_ecall;
            trap_ebreak: cause_code = mcause_ebreak;
            default:     cause_code = mcause_misaligned;
        endcase
    end

    always_comb begin
        next_state   = idle;
        csr_trap     = '0;
        trap_rd_addr = 12'h000;
        trap_target  = 32'h0;
        redirect     = 1'b0;
        ic_clean     = 1'b0;
        trap_done    = 1'b1;

        if (!active) begin
            trap_done = 1'b0;
        end else begin
            case (state)
                idle: begin
                    case (status)
                        trap_fencei: begin
                            ic_clean = 1'b1;  // single cycle pulse
                        end
                        trap_mret: begin
                            trap_rd_addr = csr_addr_mepc;
                            // word align the saved pc and step past it
                            trap_target  = {trap_rd_data[31:2], 2'b00} + 32'd4;
                            redirect     = 1'b1;
                        end
                        trap_ecall, trap_ebreak, trap_misaligned: begin
                            csr_trap   = '{en: 1'b1, addr: csr_addr_mepc, data: pc};
                            trap_done  = 1'b0;
                            next_state = write_mepc;
                        end
                        default: begin
                            next_state = idle;
                        end
                    endcase
                end
                write_mepc: begin
                    csr_trap   = '{en: 1'b1, addr: csr_addr_mcause, data: cause_code};
                    trap_done  = 1'b0;
                    next_state = write_mcause;
                end
                write_mcause: begin
                    if (status == trap_ebreak) begin
                        // step over the ebreak, debug mode parks the pc there
                        trap_target = pc + 32'd4;
                        redirect    = 1'b1;
                    end else begin
                        trap_rd_addr = csr_addr_mtvec;
                        trap_done    = 1'b0;
                        next_state   = read_mtvec;
                    end
                end
                read_mtvec: begin
                    trap_rd_addr = csr_addr_mtvec;  // keep mtvec on the target
                    trap_target  = trap_rd_data;
                    redirect     = 1'b1;
                end
                default: begin
                    next_state = idle;
                end
            endcase
        end
    end

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/100ps

module csr_file import trap_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t csr_trap,
    input  logic [11:0] trap_rd_addr,
    input  csr_access_t csr_cfg,
    input  logic [11:0] csr_rd_addr,
    output logic [31:0] trap_rd_data,
    output logic [31:0] csr_rd_data
);

    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtvec;
    csr_access_t wr;

    // controller write wins over the config port
    assign wr = csr_trap.en ? csr_trap : csr_cfg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mepc   <= 32'h0;
            mcause <= 32'h0;
            mtvec  <= 32'h0;
        end else if (wr.en) begin
            case (wr.addr)
                csr_addr_mepc: begin
                    mepc <= wr.data;
                end
                csr_addr_mcause: begin
                    mcause <= wr.data;
                end
                csr_addr_mtvec: begin
                    mtvec <= {wr.data[31:2], 2'b00};  // direct mode only
                end
                default: begin
                    mepc <= mepc;  // unmapped address, drop the write
                end
            endcase
        end
    end

    function automatic logic [31:0] read_csr(
        input logic [11:0] addr,
        input logic [31:0] epc,
        input logic [31:0] cause,
        input logic [31:0] tvec
    );
        logic [31:0] value;
        case (addr)
            csr_addr_mepc:   value = epc;
            csr_addr_mcause: value = cause;
            csr_addr_mtvec:  value = tvec;
            default:         value = 32'h0;
        endcase
        return value;
    endfunction

    // both read ports are combinational
    always_comb begin
        trap_rd_data = read_csr(trap_rd_addr, mepc, mcause, mtvec);
    end

    always_comb begin
        csr_rd_data = read_csr(csr_rd_addr, mepc, mcause, mtvec);
    end

endmodule

// ==== design/pc_sequencer.sv ====
`timescale 1ns/100ps

module pc_sequencer #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        trap_done,
    input  logic        redirect,
    input  logic [31:0] trap_target,
    input  logic        jump_valid,
    input  logic [31:0] jump_target,
    input  logic        debug_mode,
    output logic [31:0] pc
);

    logic        advance;
    logic        jump_ok;
    logic [31:0] pc_next;

    // pc moves only with trap_done high and outside debug mode
    assign advance = trap_done && !debug_mode;

    // misaligned jumps are turned into traps by the decoder
    assign jump_ok = jump_valid && (jump_target[1:0] == 2'b00);

    always_comb begin
        if (redirect) begin
            pc_next = trap_target;
        end else if (jump_ok) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

endmodule

// ==== design/trap_unit_top.sv ====
`timescale 1ns/100ps

module trap_unit_top import trap_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic        jump_valid,
    input  logic [31:0] jump_target,
    input  logic        debug_resume,
    input  csr_access_t csr_cfg,
    input  logic [11:0] csr_rd_addr,
    output logic [31:0] csr_rd_data,
    output logic [31:0] pc,
    output logic        trap_done,
    output logic        debug_mode,
    output logic        ic_clean
);

    trap_status_e status;
    csr_access_t  csr_trap;
    logic [11:0]  trap_rd_addr;
    logic [31:0]  trap_rd_data;
    logic [31:0]  trap_target;
    logic         redirect;

    trap_decoder u_trap_decoder (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .jump_valid  (jump_valid),
        .jump_target (jump_target),
        .trap_done   (trap_done),
        .debug_mode  (debug_mode),
        .status      (status)
    );

    trap_controller u_trap_controller (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .status       (status),
        .debug_resume (debug_resume),
        .trap_rd_data (trap_rd_data),
        .csr_trap     (csr_trap),
        .trap_rd_addr (trap_rd_addr),
        .trap_target  (trap_target),
        .redirect     (redirect),
        .ic_clean     (ic_clean),
        .debug_mode   (debug_mode),
        .trap_done    (trap_done)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .reset        (reset),
        .csr_trap     (csr_trap),
        .trap_rd_addr (trap_rd_addr),
        .csr_cfg      (csr_cfg),
        .csr_rd_addr  (csr_rd_addr),
        .trap_rd_data (trap_rd_data),
        .csr_rd_data  (csr_rd_data)
    );

    pc_sequencer #(
        .reset_pc (reset_pc)
    ) u_pc_sequencer (
        .clk         (clk),
        .reset       (reset),
        .trap_done   (trap_done),
        .redirect    (redirect),
        .trap_target (trap_target),
        .jump_valid  (jump_valid),
        .jump_target (jump_target),
        .debug_mode  (debug_mode),
        .pc          (pc)
    );

endmodule

// ==== dv/trap_unit_tb.sv ====
`timescale 1ns/100ps

module trap_unit_tb import trap_pkg::*; ();

    localparam logic [31:0] reset_pc     = 32'h0000_0040;
    localparam logic [31:0] park_pc      = 32'h0000_8000;  // far from every planted slot
    localparam int          wait_limit   = 20;
    localparam logic [31:0] instr_ecall  = 32'h0000_0073;
    localparam logic [31:0] instr_ebreak = 32'h0010_0073;
    localparam logic [31:0] instr_mret   = 32'h3020_0073;
    localparam logic [31:0] instr_fencei = 32'h0000_100f;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        jump_valid;
    logic [31:0] jump_target;
    logic        debug_resume;
    csr_access_t csr_cfg;
    logic [11:0] csr_rd_addr;
    logic [31:0] csr_rd_data;
    logic [31:0] pc;
    logic        trap_done;
    logic        debug_mode;
    logic        ic_clean;

    logic [31:0] imem [0:63];  // low 256 bytes of instruction memory
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] mtvec_value;

    trap_unit_top #(
        .reset_pc (reset_pc)
    ) u_trap_unit_top (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .jump_valid   (jump_valid),
        .jump_target  (jump_target),
        .debug_resume (debug_resume),
        .csr_cfg      (csr_cfg),
        .csr_rd_addr  (csr_rd_addr),
        .csr_rd_data  (csr_rd_data),
        .pc           (pc),
        .trap_done    (trap_done),
        .debug_mode   (debug_mode),
        .ic_clean     (ic_clean)
    );

    always #4 clk = ~clk;

    // op-imm filler that encodes its own address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[26:2] ^ {18'h0, addr[31:27], addr[1:0]}, 7'b0010011};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:8] == 24'h0) begin
            return imem[addr[7:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic report_problem(input string text);
        $display("ERROR %s %s", test_name, text);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    // cache clean is a single cycle pulse
    assert property (@(posedge clk) disable iff (reset) ic_clean |=> !ic_clean)
        else report_problem("ic_clean stayed high for a second cycle");

    // no pc movement while stalled or parked
    assert property (@(posedge clk) disable iff (reset)
                     (!trap_done || debug_mode) |=> $stable(pc))
        else report_problem("pc moved while trap_done was low or debug_mode was high");

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic clock_in();
        @(posedge clk);
        #1;
        instr = fetch_word(pc);  // memory follows the pc
    endtask

    task automatic settle();
        @(negedge clk);
    endtask

    task automatic step();
        clock_in();
        settle();
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        clock_in();
        csr_cfg = '{en: 1'b1, addr: addr, data: data};
        settle();
        clock_in();
        csr_cfg = '0;
        settle();
    endtask

    task automatic expect_csr(input string what, input logic [11:0] addr,
                              input logic [31:0] expected);
        clock_in();
        csr_rd_addr = addr;
        settle();
        check_value(what, expected, csr_rd_data);
    endtask

    // one cycle jump request, returns in the first cycle at the target
    task automatic go_to(input logic [31:0] target);
        clock_in();
        jump_valid  = 1'b1;
        jump_target = target;
        settle();
        clock_in();
        jump_valid = 1'b0;
        settle();
        check_value("pc at jump target", target, pc);
    endtask

    task automatic plant_and_go(input logic [31:0] addr, input logic [31:0] word);
        go_to(park_pc);
        imem[addr[7:2]] = word;
        go_to(addr);
    endtask

    // counts trap_done low cycles from the first one
    task automatic count_stall(output int low);
        low = 0;
        while (trap_done !== 1'b1 && low < wait_limit) begin
            low++;
            clock_in();
            jump_valid = 1'b0;
            csr_cfg    = '0;
            settle();
        end
        if (trap_done !== 1'b1) begin
            report_problem("trap_done stayed low past the timeout");
        end
    endtask

    task automatic run_ecall(output logic [31:0] ecall_pc);
        int low;
        ecall_pc = 32'h80 + ($urandom % 15) * 4;
        plant_and_go(ecall_pc, instr_ecall);
        count_stall(low);
        check_value("trap_done low cycles", 3, low);
        step();
        check_value("pc at handler", mtvec_value, pc);
        imem[ecall_pc[7:2]] = fill_word(ecall_pc);
    endtask

    // optional config write to mepc in the same cycle as the trap write
    task automatic run_misaligned(input logic clash);
        logic [31:0] jump_pc;
        int          low;
        clock_in();
        jump_pc     = pc;
        jump_valid  = 1'b1;
        jump_target = 32'h3000 + ($urandom & 32'hff0) + 32'd2;
        if (clash) begin
            csr_cfg = '{en: 1'b1, addr: csr_addr_mepc, data: 32'hdead_beec};
        end
        settle();
        count_stall(low);
        check_value("trap_done low cycles", 3, low);
        step();
        check_value("pc at handler", mtvec_value, pc);
        expect_csr("mepc", csr_addr_mepc, jump_pc);
        expect_csr("mcause", csr_addr_mcause, 32'd0);
    endtask

    initial begin
        logic [31:0] trap_pc;
        logic [31:0] held_pc;
        logic [31:0] prev_pc;
        logic [31:0] mepc_base;
        logic [31:0] mepc_value;
        int          low;
        void'($urandom(32'h87945557));
        for (int i = 0; i < 64; i++) begin
            imem[i] = fill_word(i * 4);
        end
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = fetch_word(reset_pc);
        jump_valid   = 1'b0;
        jump_target  = 32'h0;
        debug_resume = 1'b0;
        csr_cfg      = '0;
        csr_rd_addr  = 12'h000;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        settle();

        begin_test("reset_and_sequence");
        check_value("pc after reset", reset_pc, pc);
        check_value("trap_done after reset", 0, trap_done);
        check_value("debug_mode after reset", 0, debug_mode);
        check_value("ic_clean after reset", 0, ic_clean);
        step();
        check_value("pc held in first cycle", reset_pc, pc);
        check_value("trap_done once decoding", 1, trap_done);
        repeat (5) begin
            prev_pc = pc;
            step();
            check_value("sequential pc", prev_pc + 4, pc);
        end
        expect_csr("mepc after reset", csr_addr_mepc, 32'h0);
        expect_csr("mcause after reset", csr_addr_mcause, 32'h0);
        expect_csr("mtvec after reset", csr_addr_mtvec, 32'h0);
        go_to(32'h2000 + ($urandom & 32'hffc));
        end_test();

        begin_test("ecall");
        mtvec_value = 32'h1000 + ($urandom & 32'hffc);
        write_csr(csr_addr_mtvec, mtvec_value);
        expect_csr("mtvec", csr_addr_mtvec, mtvec_value);
        run_ecall(trap_pc);
        expect_csr("mepc", csr_addr_mepc, trap_pc);
        expect_csr("mcause", csr_addr_mcause, 32'd11);
        end_test();

        begin_test("misaligned_jump");
        run_misaligned(1'b0);
        end_test();

        begin_test("ebreak");
        trap_pc = 32'h80 + ($urandom % 15) * 4;
        plant_and_go(trap_pc, instr_ebreak);
        count_stall(low);
        check_value("trap_done low cycles", 2, low);
        check_value("debug_mode before edge 3", 0, debug_mode);
        step();
        check_value("debug_mode after edge 3", 1, debug_mode);
        imem[trap_pc[7:2]] = fill_word(trap_pc);
        held_pc = pc;
        check_value("pc parked past ebreak", trap_pc + 4, held_pc);
        repeat (4) begin
            step();
            check_value("pc held in debug mode", held_pc, pc);
        end
        expect_csr("mcause", csr_addr_mcause, 32'd3);
        expect_csr("mepc", csr_addr_mepc, trap_pc);
        clock_in();
        debug_resume = 1'b1;
        settle();
        clock_in();
        debug_resume = 1'b0;
        settle();
        check_value("debug_mode after resume", 0, debug_mode);
        check_value("pc when debug_mode falls", held_pc, pc);
        step();
        check_value("pc after resume", held_pc + 4, pc);
        end_test();

        begin_test("mret");
        go_to(park_pc);
        mtvec_value = 32'hc0 + ($urandom % 16) * 4;  // handler is a lone mret
        write_csr(csr_addr_mtvec, mtvec_value);
        imem[mtvec_value[7:2]] = instr_mret;
        run_ecall(trap_pc);
        step();
        check_value("pc after mret", trap_pc + 4, pc);
        go_to(park_pc);
        mepc_base  = 32'h5000 + ($urandom & 32'hffc);
        mepc_value = mepc_base + 32'd3;  // low bits set on purpose
        write_csr(csr_addr_mepc, mepc_value);
        expect_csr("mepc preload", csr_addr_mepc, mepc_value);
        go_to(mtvec_value);
        step();
        check_value("pc after mret to unaligned mepc", mepc_base + 32'd4, pc);
        imem[mtvec_value[7:2]] = fill_word(mtvec_value);
        end_test();

        begin_test("fencei_and_csr_priority");
        trap_pc = 32'h80 + ($urandom % 15) * 4;
        plant_and_go(trap_pc, instr_fencei);
        check_value("ic_clean in fence.i cycle", 1, ic_clean);
        imem[trap_pc[7:2]] = fill_word(trap_pc);
        step();
        check_value("ic_clean after fence.i", 0, ic_clean);
        check_value("pc after fence.i", trap_pc + 4, pc);
        mtvec_value = 32'h1000 + ($urandom & 32'hffc);
        write_csr(csr_addr_mtvec, mtvec_value);
        run_misaligned(1'b1);
        end_test();

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // hard stop if a loop above never returns
    initial begin
        #20000;
        $display("ERROR simulation ran past its time limit");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== trap_unit.f ====
design/trap_pkg.sv
design/trap_decoder.sv
design/trap_controller.sv
design/csr_file.sv
design/pc_sequencer.sv
design/trap_unit_top.sv
dv/trap_unit_tb.sv

// ==== Bender.yml ====
package:
  name: trap_unit

sources:
  - files:
      - design/trap_pkg.sv
      - design/trap_decoder.sv
      - design/trap_controller.sv
      - design/csr_file.sv
      - design/pc_sequencer.sv
      - design/trap_unit_top.sv
  - target: test
    files:
      - dv/trap_unit_tb.sv
